/* hw/bayer_binning.sv */
`timescale 1ns/1ps

module bayer_binning (
    input  logic                      mipi_byte_clock,
    input  logic                      mipi_byte_reset_n,
    input  camera_pkg::bayer_stream_t stream_i,
    output camera_pkg::rgb_stream_t   pixel_o
);

    import camera_pkg::*;

    color_t                red_line [IMAGE_WIDTH]; // R of each quad from the upper row
    color_t                green_line [IMAGE_WIDTH]; // First G of each quad
    raw_pixel_t            sample_q;
    sensor_coord_t         col_count;
    logic                  line_odd;
    logic                  line_valid_q;
    logic                  bottom_row;
    logic                  odd_col;
    quad_index_t           quad;
    logic [$bits(color_t):0] green_sum;
    color_t                red_q;
    color_t                green_q;
    color_t                blue_q;
    logic                  pixel_valid_q;
    logic                  frame_valid_q;

    always_comb begin
        bottom_row = line_odd ^ CROP_ROW_PHASE;
        odd_col    = col_count[0] ^ CROP_COL_PHASE;
        quad       = quad_index_t'(col_count >> 1);
        green_sum  = {1'b0, green_line[quad]} + {1'b0, sample_q};
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            col_count     <= '0;
            line_odd      <= 1'b0;
            line_valid_q  <= 1'b0;
            pixel_valid_q <= 1'b0;
            frame_valid_q <= 1'b0;
        end else begin
            line_valid_q  <= stream_i.line_valid;
            frame_valid_q <= stream_i.frame_valid;
            pixel_valid_q <= stream_i.line_valid && bottom_row && odd_col; // B closes the quad

            if (stream_i.line_valid) begin
                col_count <= col_count + 1;
            end else begin
                col_count <= '0;
            end

            if (!stream_i.frame_valid) begin
                line_odd <= 1'b0;
            end else if (line_valid_q && !stream_i.line_valid) begin
                line_odd <= !line_odd;
            end
        end
    end

    // Upper row fills the buffer, lower row reads it back
    always_ff @(posedge mipi_byte_clock) begin
        if (stream_i.line_valid) begin
            if (!odd_col) begin
                sample_q <= stream_i.data; // R above, G2 below
            end else if (!bottom_row) begin
                red_line[quad]   <= sample_q;
                green_line[quad] <= stream_i.data;
            end else begin
                red_q   <= red_line[quad];
                green_q <= green_sum[$bits(color_t):1];
                blue_q  <= stream_i.data;
            end
        end
    end

    always_comb begin
        pixel_o.red         = red_q;
        pixel_o.green       = green_q;
        pixel_o.blue        = blue_q;
        pixel_o.pixel_valid = pixel_valid_q;
        pixel_o.frame_valid = frame_valid_q;
    end

    // Lower row must not run past the buffered quads
    lower_row_width: assert property (
        @(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        stream_i.line_valid && bottom_row |-> col_count <= CROP_X_END - CROP_X_START
    );

endmodule

/* hw/bayer_crop.sv */
`timescale 1ns/1ps

module bayer_crop (
    input  logic                      mipi_byte_clock,
    input  logic                      mipi_byte_reset_n,
    input  camera_pkg::bayer_stream_t stream_i,
    output camera_pkg::bayer_stream_t stream_o
);

    import camera_pkg::*;

    sensor_coord_t x_count;
    sensor_coord_t y_count;
    logic          line_valid_q;
    logic          frame_valid_q;
    logic          keep_q;
    logic          in_window;
    raw_pixel_t    data_q;

    always_comb begin
        in_window = stream_i.line_valid && stream_i.frame_valid
                 && x_count >= CROP_X_START && x_count <= CROP_X_END
                 && y_count >= CROP_Y_START && y_count <= CROP_Y_END;
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            x_count       <= '0;
            y_count       <= '0;
            line_valid_q  <= 1'b0;
            frame_valid_q <= 1'b0;
            keep_q        <= 1'b0;
        end else begin
            line_valid_q  <= stream_i.line_valid;
            frame_valid_q <= stream_i.frame_valid;
            keep_q        <= in_window;

            if (stream_i.line_valid) begin
                x_count <= x_count + 1;
            end else begin
                x_count <= '0; // Restart column count between lines
            end

            if (stream_i.frame_valid && !frame_valid_q) begin
                y_count <= '0; // Frame start
            end else if (line_valid_q && !stream_i.line_valid) begin
                y_count <= y_count + 1; // Line end
            end
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        data_q <= stream_i.data;
    end

    always_comb begin
        stream_o.data        = data_q;
        stream_o.line_valid  = keep_q;
        stream_o.frame_valid = frame_valid_q;
    end

    line_inside_frame: assert property (
        @(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        stream_i.line_valid |-> stream_i.frame_valid
    );

endmodule

/* hw/camera_metering.sv */
`timescale 1ns/1ps

module camera_metering (
    input  logic                         mipi_byte_clock,
    input  logic                         mipi_byte_reset_n,
    input  camera_pkg::bayer_stream_t    bayer_i,
    output camera_pkg::metering_result_t result_o,
    output logic                         result_valid_o,
    input  logic                         result_ready_i
);

    import camera_pkg::*;

    bayer_stream_t cropped;
    rgb_stream_t   binned;
    meter_rgb_t    center_meter;
    meter_rgb_t    average_meter;
    logic          center_ready;
    logic          average_ready;

    bayer_crop crop (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .stream_i          (bayer_i),
        .stream_o          (cropped)
    );

    bayer_binning binning (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .stream_i          (cropped),
        .pixel_o           (binned)
    );

    window_metering #(.WINDOW_SIZE(CENTER_SIZE)) center_metering (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .pixel_i           (binned),
        .meter_o           (center_meter),
        .ready_o           (center_ready)
    );

    window_metering #(.WINDOW_SIZE(IMAGE_WIDTH)) average_metering (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .pixel_i           (binned),
        .meter_o           (average_meter),
        .ready_o           (average_ready)
    );

    metering_report report (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .center_i          (center_meter),
        .center_ready_i    (center_ready),
        .average_i         (average_meter),
        .average_ready_i   (average_ready),
        .result_o          (result_o),
        .result_valid_o    (result_valid_o),
        .result_ready_i    (result_ready_i)
    );

endmodule

/* hw/camera_pkg.sv */
package camera_pkg;

    localparam int SENSOR_WIDTH = 20;
    localparam int SENSOR_HEIGHT = 18;

    // Headroom so the counters never wrap inside a line or frame
    localparam int SENSOR_COORD_BITS =
        $clog2(SENSOR_WIDTH > SENSOR_HEIGHT ? SENSOR_WIDTH : SENSOR_HEIGHT) + 1;

    typedef logic [SENSOR_COORD_BITS-1:0] sensor_coord_t;

    localparam sensor_coord_t CROP_X_START = 2;
    localparam sensor_coord_t CROP_X_END = 17;
    localparam sensor_coord_t CROP_Y_START = 2; // Even, kept area opens on an R G line
    localparam sensor_coord_t CROP_Y_END = 17;

    // Bayer phase of the first kept sample
    localparam bit CROP_ROW_PHASE = CROP_Y_START[0];
    localparam bit CROP_COL_PHASE = CROP_X_START[0];

    localparam int IMAGE_WIDTH = 8;
    localparam int IMAGE_HEIGHT = 8;
    localparam int CENTER_SIZE = 4;

    typedef logic [9:0] raw_pixel_t;
    typedef logic [9:0] color_t;
    typedef logic [7:0] meter_t;
    typedef logic [7:0] drop_count_t;
    typedef logic [$clog2(IMAGE_WIDTH):0] image_coord_t;
    typedef logic [$clog2(IMAGE_WIDTH)-1:0] quad_index_t;

    typedef struct packed {
        raw_pixel_t data;
        logic       line_valid;
        logic       frame_valid;
    } bayer_stream_t;

    typedef struct packed {
        color_t red;
        color_t green;
        color_t blue;
        logic   pixel_valid;
        logic   frame_valid;
    } rgb_stream_t;

    typedef struct packed {
        meter_t red;
        meter_t green;
        meter_t blue;
    } meter_rgb_t;

    typedef struct packed {
        meter_rgb_t  center;
        meter_rgb_t  average;
        drop_count_t dropped;
    } metering_result_t;

endpackage

/* hw/metering_report.sv */
`timescale 1ns/1ps

module metering_report (
    input  logic                         mipi_byte_clock,
    input  logic                         mipi_byte_reset_n,
    input  camera_pkg::meter_rgb_t       center_i,
    input  logic                         center_ready_i,
    input  camera_pkg::meter_rgb_t       average_i,
    input  logic                         average_ready_i,
    output camera_pkg::metering_result_t result_o,
    output logic                         result_valid_o,
    input  logic                         result_ready_i
);

    import camera_pkg::*;

    meter_rgb_t  center_q;
    meter_rgb_t  average_q;
    drop_count_t drop_count;
    logic        frame_done;
    logic        slot_free;
    logic        taken;

    always_comb begin
        frame_done = center_ready_i && average_ready_i;
        taken      = result_valid_o && result_ready_i;
        slot_free  = !result_valid_o || result_ready_i; // Slot empties this cycle

        result_o.center  = center_q;
        result_o.average = average_q;
        result_o.dropped = drop_count;
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            result_valid_o <= 1'b0;
            drop_count     <= '0;
        end else begin
            if (frame_done && slot_free) begin
                result_valid_o <= 1'b1;
            end else if (taken) begin
                result_valid_o <= 1'b0;
            end

            if (taken) begin
                drop_count <= '0;
            end else if (frame_done && !slot_free && drop_count != '1) begin
                drop_count <= drop_count + 1; // Saturates at 255
            end
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        if (frame_done && slot_free) begin
            center_q  <= center_i;
            average_q <= average_i;
        end
    end

    // Both meters see the same frame_valid edge
    meters_in_step: assert property (
        @(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        center_ready_i == average_ready_i
    );

    // Drop count may only climb while the result waits
    result_held: assert property (
        @(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        result_valid_o && !result_ready_i |=> result_valid_o
            && $stable(result_o.center) && $stable(result_o.average)
            && result_o.dropped >= $past(result_o.dropped)
    );

endmodule

/* hw/window_metering.sv */
`timescale 1ns/1ps

module window_metering #(
    parameter int WINDOW_SIZE = camera_pkg::CENTER_SIZE
) (
    input  logic                    mipi_byte_clock,
    input  logic                    mipi_byte_reset_n,
    input  camera_pkg::rgb_stream_t pixel_i,
    output camera_pkg::meter_rgb_t  meter_o,
    output logic                    ready_o
);

    import camera_pkg::*;

    localparam int SUM_WIDTH = $bits(color_t) + 2 * $clog2(WINDOW_SIZE);
    localparam image_coord_t X_FIRST = image_coord_t'((IMAGE_WIDTH - WINDOW_SIZE) / 2);
    localparam image_coord_t Y_FIRST = image_coord_t'((IMAGE_HEIGHT - WINDOW_SIZE) / 2);
    localparam image_coord_t SPAN = image_coord_t'(WINDOW_SIZE);

    typedef logic [SUM_WIDTH-1:0] sum_t;

    image_coord_t x_pos;
    image_coord_t y_pos;
    logic         in_window;
    logic         frame_valid_q;
    logic         frame_end;
    sum_t         red_sum;
    sum_t         green_sum;
    sum_t         blue_sum;

    // Offsets left of or above the window wrap to large values
    always_comb begin
        in_window = pixel_i.pixel_valid
                 && image_coord_t'(x_pos - X_FIRST) < SPAN
                 && image_coord_t'(y_pos - Y_FIRST) < SPAN;
        frame_end = frame_valid_q && !pixel_i.frame_valid;
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            x_pos         <= '0;
            y_pos         <= '0;
            frame_valid_q <= 1'b0;
            ready_o       <= 1'b0;
            red_sum       <= '0;
            green_sum     <= '0;
            blue_sum      <= '0;
        end else begin
            frame_valid_q <= pixel_i.frame_valid;
            ready_o       <= frame_end;

            if (!pixel_i.frame_valid) begin
                x_pos <= '0;
                y_pos <= '0;
            end else if (pixel_i.pixel_valid) begin
                if (x_pos == IMAGE_WIDTH - 1) begin
                    x_pos <= '0;
                    y_pos <= y_pos + 1;
                end else begin
                    x_pos <= x_pos + 1;
                end
            end

            if (frame_end) begin
                red_sum   <= '0;
                green_sum <= '0;
                blue_sum  <= '0;
            end else if (in_window) begin
                red_sum   <= red_sum + sum_t'(pixel_i.red);
                green_sum <= green_sum + sum_t'(pixel_i.green);
                blue_sum  <= blue_sum + sum_t'(pixel_i.blue);
            end
        end
    end

    // Top bits of the sum give the average without a divider
    always_ff @(posedge mipi_byte_clock) begin
        if (frame_end) begin
            meter_o.red   <= red_sum[SUM_WIDTH-1 -: $bits(meter_t)];
            meter_o.green <= green_sum[SUM_WIDTH-1 -: $bits(meter_t)];
            meter_o.blue  <= blue_sum[SUM_WIDTH-1 -: $bits(meter_t)];
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the camera metering testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_camera_metering -o tb_camera_metering
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_camera_metering > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Regression failed" "$LOG"; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
exit 0

/* sim/metering_stimulus.txt */
# base xstep ystep holdoff  center_r center_g center_b  average_r average_g average_b  dropped
# sample = min(base + x*xstep + y*ystep, 1023) over sensor x and y, holdoff in cycles
   0   0   0    0     0   0   0     0   0   0   0
 512   0   0    0   128 128 128   128 128 128   0
 517   0   0    0   129 129 129   129 129 129   0
1023   0   0    0   255 255 255   255 255 255   0
 100  10   0    0    47  48  50    47  48  50   0
 200   3   0    0    56  57  57    56  57  57   0
   0  50   0    0   112 118 125   112 118 125   0
  50  20  30    0   125 131 137   125 131 137   0
   0  40  40    0   180 190 199   176 184 192   0
 300   0  60    0   210 215 221   198 203 208   0
 256   8   0   30    82  83  84    82  83  84   0
 400   0   0  600   100 100 100   100 100 100   1
 800   0   0    0   200 200 200   200 200 200   0
 100   5   5    0    47  48  50    47  48  50   0
1023   5   5    0   255 255 255   255 255 255   0

/* sim/tb_camera_metering.sv */
`timescale 1ns/1ps

module tb_camera_metering;

    import camera_pkg::*;

    localparam string STIMULUS_FILE = "sim/metering_stimulus.txt";

    logic             mipi_byte_clock = 1'b0;
    logic             mipi_byte_reset_n;
    bayer_stream_t    bayer;
    metering_result_t result;
    logic             result_valid;
    logic             result_ready;

    int          base_q[$];
    int          xstep_q[$];
    int          ystep_q[$];
    int          hold_q[$];
    meter_rgb_t  center_exp[$];
    meter_rgb_t  average_exp[$];
    drop_count_t dropped_exp[$];
    int          results_expected = 0;
    int          results_taken = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    logic [31:0] lcg_state = 32'hd7b60244;

    camera_metering dut (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .bayer_i           (bayer),
        .result_o          (result),
        .result_valid_o    (result_valid),
        .result_ready_i    (result_ready)
    );

    always #5 mipi_byte_clock = !mipi_byte_clock;

    always @(posedge mipi_byte_clock) begin
        cycle_count <= cycle_count + 1;
        if (result_valid && result_ready) begin
            results_taken <= results_taken + 1; // Every handshake, expected or not
        end
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, results still outstanding", cycle_count);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic step();
        @(posedge mipi_byte_clock);
        #1; // Drive and sample just after the edge
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic idle_gap();
        lcg_state = lcg_next(lcg_state);
        repeat (1 + int'(lcg_state[18:16])) step(); // 1 to 8 idle cycles
    endtask

    task automatic check_meter(input string name, input meter_rgb_t expected,
                               input meter_rgb_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s expected r=%0d g=%0d b=%0d actual r=%0d g=%0d b=%0d", name,
                     expected.red, expected.green, expected.blue,
                     actual.red, actual.green, actual.blue);
            abort_run();
        end
    endtask

    task automatic check_dropped(input string name, input drop_count_t expected,
                                 input drop_count_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s expected %0d actual %0d", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic load_stimulus();
        int fd;
        int ch;
        int n;
        int max_hold;
        int v [11];
        max_hold = 0;
        fd = $fopen(STIMULUS_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file %s", STIMULUS_FILE);
            abort_run();
        end
        repeat (2) begin // Column description lines
            ch = $fgetc(fd);
            while (ch != 32'h0a && ch != -1) begin
                ch = $fgetc(fd);
            end
        end
        n = $fscanf(fd, "%d %d %d %d %d %d %d %d %d %d %d", v[0], v[1], v[2], v[3],
                    v[4], v[5], v[6], v[7], v[8], v[9], v[10]);
        while (n == 11) begin
            base_q.push_back(v[0]);
            xstep_q.push_back(v[1]);
            ystep_q.push_back(v[2]);
            hold_q.push_back(v[3]);
            center_exp.push_back({meter_t'(v[4]), meter_t'(v[5]), meter_t'(v[6])});
            average_exp.push_back({meter_t'(v[7]), meter_t'(v[8]), meter_t'(v[9])});
            dropped_exp.push_back(drop_count_t'(v[10]));
            max_hold = (v[3] > max_hold) ? v[3] : max_hold;
            results_expected = results_expected + 1 - v[10]; // Dropped frames give no result
            n = $fscanf(fd, "%d %d %d %d %d %d %d %d %d %d %d", v[0], v[1], v[2], v[3],
                        v[4], v[5], v[6], v[7], v[8], v[9], v[10]);
        end
        $fclose(fd);
        if (base_q.size() == 0) begin
            $display("The stimulus file holds no frames");
            abort_run();
        end
        cycle_limit = base_q.size() * (SENSOR_HEIGHT * (SENSOR_WIDTH + 8) + max_hold + 50);
    endtask

    task automatic send_frame(input int base, input int xstep, input int ystep);
        int x;
        int y;
        int value;
        bayer.frame_valid = 1'b1;
        idle_gap();
        for (y = 0; y < SENSOR_HEIGHT; y++) begin
            for (x = 0; x < SENSOR_WIDTH; x++) begin
                value            = base + x * xstep + y * ystep;
                bayer.data       = raw_pixel_t'((value > 1023) ? 1023 : value);
                bayer.line_valid = 1'b1;
                step();
            end
            bayer.line_valid = 1'b0;
            idle_gap();
        end
        bayer.frame_valid = 1'b0;
        idle_gap();
    endtask

    task automatic drive_frames();
        foreach (base_q[i]) begin
            send_frame(base_q[i], xstep_q[i], ystep_q[i]);
        end
    endtask

    task automatic collect_results();
        int idx;
        metering_result_t got;
        idx = 0;
        while (idx < base_q.size()) begin
            result_ready = (hold_q[idx] == 0);
            while (!result_valid) begin
                step();
            end
            repeat (hold_q[idx]) step();
            got          = result;
            result_ready = 1'b1; // Handshake completes on the next edge
            step();
            check_meter($sformatf("frame %0d center", idx + 1), center_exp[idx], got.center);
            check_meter($sformatf("frame %0d average", idx + 1), average_exp[idx], got.average);
            check_dropped($sformatf("frame %0d dropped", idx + 1), dropped_exp[idx],
                          got.dropped);
            idx = idx + 1 + int'(dropped_exp[idx]);
        end
    endtask

    initial begin
        mipi_byte_reset_n = 1'b0;
        bayer             = '0;
        result_ready      = 1'b0;
        load_stimulus();
        repeat (2) @(posedge mipi_byte_clock);
        #1;
        mipi_byte_reset_n = 1'b1;
        fork
            drive_frames();
            collect_results();
        join
        repeat (10) step();
        if (results_taken != results_expected || result_valid) begin
            $display("Took %0d results of %0d, extra result pending: %0d",
                     results_taken, results_expected, result_valid);
            abort_run();
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

/* src.f */
hw/camera_pkg.sv
hw/bayer_crop.sv
hw/bayer_binning.sv
hw/window_metering.sv
hw/metering_report.sv
hw/camera_metering.sv
sim/tb_camera_metering.sv
